/* verilog/m1_macros.svh */
`ifndef M1_MACROS_SVH
`define M1_MACROS_SVH

// cp0 register numbers, select 0
`define CP0_BADVADDR      5'd8
`define CP0_ENTRYHI       5'd10
`define CP0_STATUS        5'd12
`define CP0_CAUSE         5'd13
`define CP0_EPC           5'd14

// exception entry points, BEV=1
`define EXC_VECTOR        32'hbfc0_0380
`define REFILL_VECTOR     32'hbfc0_0200

// cache attribute from the tlb c field
`define CACHE_UNCACHED    3'd2

// vaddr[31:29] of kseg0, kseg1 differs only in bit 29
`define KSEG_UNMAPPED_TOP 3'b100

`endif

/* verilog/m1_pkg.sv */
`default_nettype none

package m1_pkg;

    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,
        exc_ov   = 5'd12
    } exccode_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;   // also the data virtual address
        logic [4:0]  dest;
        logic        gr_we;
        logic        load_op;
        logic        mem_we;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        inst_mfc0;
        logic        inst_mtc0;
        logic        inst_eret;
        logic [4:0]  cp0_rd;
        logic [2:0]  cp0_sel;
        logic        bd;           // in a branch delay slot
        logic        ex;           // exception from an earlier stage
        exccode_e    exccode;
        logic [31:0] rt_value;
    } es_to_m1_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        gr_we;
        logic        load_op;
        logic        ex;
        logic [31:0] rt_value;
    } m1_to_ms_t;

    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic      found;
        tlb_page_t even;
        tlb_page_t odd;
    } tlb_lookup_t;

    typedef struct packed {
        logic        op;           // 1 = store
        logic [19:0] tag;
        logic [7:0]  index;
        logic [3:0]  offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        uncached;
    } dcache_req_t;

endpackage

`default_nettype wire

/* verilog/dtlb_check.sv */
`timescale 1ns/10ps
`default_nettype none

`include "m1_macros.svh"

module dtlb_check (
    input  wire logic [31:0]         vaddr,
    input  wire logic                load_op,
    input  wire logic                mem_we,
    input  wire m1_pkg::tlb_lookup_t tlb_result,
    output logic [19:0]              ptag,
    output logic                     uncached,
    output logic                     tlb_ex,
    output m1_pkg::exccode_e         tlb_exccode,
    output logic                     tlb_refill
);

    logic              unmapped;
    logic              mem_op;
    m1_pkg::tlb_page_t page;
    logic              miss;
    logic              invalid;
    logic              dirty_fault;

    assign unmapped = ((vaddr[31:29] & 3'b110) == `KSEG_UNMAPPED_TOP);   // kseg0 or kseg1
    assign mem_op   = load_op | mem_we;
    assign page     = vaddr[12] ? tlb_result.odd : tlb_result.even;   // odd half on bit 12

    assign miss        = !tlb_result.found;
    assign invalid     = tlb_result.found && !page.v;
    assign dirty_fault = tlb_result.found && page.v && mem_we && !page.d;

    always_comb begin
        if (unmapped) begin
            ptag     = {3'b000, vaddr[28:12]};
            uncached = vaddr[29];                  // kseg1
        end else begin
            ptag     = page.pfn;
            uncached = (page.c == `CACHE_UNCACHED);
        end
    end

    assign tlb_ex     = mem_op && !unmapped && (miss || invalid || dirty_fault);
    assign tlb_refill = tlb_ex && miss;

    always_comb begin
        if (dirty_fault) begin
            tlb_exccode = m1_pkg::exc_mod;
        end else if (mem_we) begin
            tlb_exccode = m1_pkg::exc_tlbs;
        end else begin
            tlb_exccode = m1_pkg::exc_tlbl;
        end
    end

endmodule

`default_nettype wire

/* verilog/cp0_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "m1_macros.svh"

module cp0_regs (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             commit,
    input  wire logic             inst_mtc0,
    input  wire logic             inst_eret,
    input  wire logic             ex,
    input  wire m1_pkg::exccode_e exccode,
    input  wire logic             bd,
    input  wire logic [31:0]      pc,
    input  wire logic [31:0]      bad_vaddr,
    input  wire logic [4:0]       cp0_rd,
    input  wire logic [2:0]       cp0_sel,
    input  wire logic [31:0]      wdata,
    input  wire logic [5:0]       ext_int,
    output logic [31:0]           cp0_rdata,
    output logic [31:0]           epc,
    output logic                  status_ie,
    output logic                  status_exl,
    output logic [7:0]            status_im,
    output logic [7:0]            cause_ip,
    output logic [7:0]            entryhi_asid
);

    logic        exc_commit;
    logic        eret_commit;
    logic        wr_en;
    logic        addr_exc;
    logic        tlb_exc;
    logic        cause_bd;
    logic [5:0]  cause_ip_hw;
    logic [1:0]  cause_ip_sw;
    logic [4:0]  cause_exccode;
    logic [31:0] badvaddr;
    logic [18:0] entryhi_vpn2;

    assign exc_commit  = commit && ex;
    assign eret_commit = commit && inst_eret && !ex;
    assign wr_en       = commit && inst_mtc0 && !ex && (cp0_sel == 3'd0);

    assign tlb_exc  = (exccode == m1_pkg::exc_tlbl) || (exccode == m1_pkg::exc_tlbs) ||
                      (exccode == m1_pkg::exc_mod);
    assign addr_exc = tlb_exc || (exccode == m1_pkg::exc_adel) ||
                      (exccode == m1_pkg::exc_ades);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
            status_im  <= 8'h00;
        end else if (exc_commit) begin
            status_exl <= 1'b1;
        end else if (eret_commit) begin
            status_exl <= 1'b0;
        end else if (wr_en && cp0_rd == `CP0_STATUS) begin
            status_im  <= wdata[15:8];
            status_exl <= wdata[1];
            status_ie  <= wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd      <= 1'b0;
            cause_ip_hw   <= 6'd0;
            cause_ip_sw   <= 2'd0;
            cause_exccode <= 5'd0;
        end else begin
            cause_ip_hw <= ext_int;                     // sampled each cycle
            if (exc_commit) begin
                cause_bd      <= bd;
                cause_exccode <= exccode;
            end else if (wr_en && cp0_rd == `CP0_CAUSE) begin
                cause_ip_sw <= wdata[9:8];              // only the soft bits are writable
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit) begin
            epc <= bd ? pc - 32'd4 : pc;                // point at the branch
        end else if (wr_en && cp0_rd == `CP0_EPC) begin
            epc <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit && addr_exc) begin
            badvaddr <= bad_vaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit && tlb_exc) begin
            entryhi_vpn2 <= bad_vaddr[31:13];
        end else if (wr_en && cp0_rd == `CP0_ENTRYHI) begin
            entryhi_vpn2 <= wdata[31:13];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entryhi_asid <= 8'h00;
        end else if (wr_en && cp0_rd == `CP0_ENTRYHI) begin
            entryhi_asid <= wdata[7:0];
        end
    end

    assign cause_ip = {cause_ip_hw, cause_ip_sw};

    always_comb begin
        cp0_rdata = 32'h0;
        if (cp0_sel == 3'd0) begin
            case (cp0_rd)
                `CP0_BADVADDR: cp0_rdata = badvaddr;
                `CP0_ENTRYHI:  cp0_rdata = {entryhi_vpn2, 5'd0, entryhi_asid};
                `CP0_STATUS:   cp0_rdata = {9'd0, 1'b1, 6'd0, status_im, 6'd0,
                                            status_exl, status_ie};   // bev fixed at 1
                `CP0_CAUSE:    cp0_rdata = {cause_bd, 15'd0, cause_ip, 1'b0,
                                            cause_exccode, 2'b00};
                `CP0_EPC:      cp0_rdata = epc;
                default:       cp0_rdata = 32'h0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/m1_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "m1_macros.svh"

module m1_stage (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                es_valid,
    input  wire m1_pkg::es_to_m1_t   es_bus,
    output logic                     m1_allowin,
    input  wire logic                ms_allowin,
    output logic                     ms_valid_out,
    output m1_pkg::m1_to_ms_t        ms_bus,
    input  wire logic [5:0]          ext_int,
    input  wire m1_pkg::tlb_lookup_t tlb_result,
    output logic [7:0]               entryhi_asid,
    output logic                     dcache_valid,
    output m1_pkg::dcache_req_t      dcache_req,
    input  wire logic                dcache_busy,
    output logic                     flush,
    output logic [31:0]              flush_target,
    output logic                     tlb_buffer_flush,
    output logic [4:0]               fwd_dest,
    output logic [31:0]              fwd_result,
    output logic                     fwd_load,
    output logic                     status_ie,
    output logic                     status_exl,
    output logic [7:0]               status_im,
    output logic [7:0]               cause_ip
);

    logic              valid;
    m1_pkg::es_to_m1_t r;
    logic              mem_op;
    logic              ready_go;
    logic              commit;
    logic [19:0]       ptag;
    logic              uncached;
    logic              tlb_ex;
    m1_pkg::exccode_e  tlb_exccode;
    logic              tlb_refill;
    logic              ex_m;
    m1_pkg::exccode_e  exccode_m;
    logic              refill_m;
    logic              refetch;
    logic [31:0]       cp0_rdata;
    logic [31:0]       epc;
    logic [31:0]       result;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (m1_allowin) begin
            valid <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && m1_allowin) begin
            r <= es_bus;
        end
    end

    assign mem_op       = r.load_op | r.mem_we;
    assign ready_go     = ex_m || !mem_op || !dcache_busy;
    assign m1_allowin   = !valid || (ready_go && ms_allowin);
    assign ms_valid_out = valid && ready_go;
    assign commit       = ms_valid_out && ms_allowin;

    dtlb_check dtlb_check_inst (
        .vaddr       (r.alu_result),
        .load_op     (r.load_op),
        .mem_we      (r.mem_we),
        .tlb_result  (tlb_result),
        .ptag        (ptag),
        .uncached    (uncached),
        .tlb_ex      (tlb_ex),
        .tlb_exccode (tlb_exccode),
        .tlb_refill  (tlb_refill)
    );

    // the exception carried in from earlier stages takes priority
    assign ex_m      = r.ex || tlb_ex;
    assign exccode_m = r.ex ? r.exccode : tlb_exccode;
    assign refill_m  = !r.ex && tlb_refill;
    assign refetch   = r.inst_mtc0 && (r.cp0_rd == `CP0_ENTRYHI) && !ex_m;

    cp0_regs cp0_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .commit       (commit),
        .inst_mtc0    (r.inst_mtc0),
        .inst_eret    (r.inst_eret),
        .ex           (ex_m),
        .exccode      (exccode_m),
        .bd           (r.bd),
        .pc           (r.pc),
        .bad_vaddr    (r.alu_result),
        .cp0_rd       (r.cp0_rd),
        .cp0_sel      (r.cp0_sel),
        .wdata        (r.rt_value),       // mtc0 source is rt
        .ext_int      (ext_int),
        .cp0_rdata    (cp0_rdata),
        .epc          (epc),
        .status_ie    (status_ie),
        .status_exl   (status_exl),
        .status_im    (status_im),
        .cause_ip     (cause_ip),
        .entryhi_asid (entryhi_asid)
    );

    // request only on the commit cycle so the cache sees it once
    assign dcache_valid = valid && mem_op && !ex_m && !r.inst_eret && !dcache_busy &&
                          ms_allowin;

    assign dcache_req.op       = r.mem_we;
    assign dcache_req.tag      = ptag;
    assign dcache_req.index    = r.alu_result[11:4];
    assign dcache_req.offset   = r.alu_result[3:0];
    assign dcache_req.wstrb    = r.mem_we ? r.wstrb : 4'h0;
    assign dcache_req.wdata    = r.wdata;
    assign dcache_req.uncached = uncached;

    assign result = r.inst_mfc0 ? cp0_rdata : r.alu_result;

    assign ms_bus.pc       = r.pc;
    assign ms_bus.result   = result;
    assign ms_bus.dest     = r.dest;
    assign ms_bus.gr_we    = r.gr_we;
    assign ms_bus.load_op  = r.load_op;
    assign ms_bus.ex       = ex_m;
    assign ms_bus.rt_value = r.rt_value;

    assign fwd_dest   = r.dest & {5{valid && r.gr_we}};   // zero means no bypass
    assign fwd_result = result;
    assign fwd_load   = valid && r.load_op;

    assign flush            = commit && (ex_m || r.inst_eret || refetch);
    assign tlb_buffer_flush = commit && refetch;

    always_comb begin
        if (ex_m) begin
            flush_target = refill_m ? `REFILL_VECTOR : `EXC_VECTOR;
        end else if (r.inst_eret) begin
            flush_target = epc;
        end else begin
            flush_target = r.pc + 32'd4;              // refetch after entryhi write
        end
    end

endmodule

`default_nettype wire

/* test/m1_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module m1_properties (
    input wire logic clk,
    input wire logic reset,
    input wire logic dcache_valid,
    input wire logic dcache_busy,
    input wire logic ms_valid_out,
    input wire logic flush
);

    // the cache may only see a request while it is free
    req_not_busy: assert property (@(posedge clk) disable iff (reset)
        !(dcache_valid && dcache_busy))
        else $error("cache request raised while dcache_busy is high");

    empty_after_reset: assert property (@(posedge clk) reset |=> !ms_valid_out)
        else $error("ms_valid_out high in the cycle after reset");

    flush_on_commit: assert property (@(posedge clk) disable iff (reset)
        flush |-> ms_valid_out)   // flush only comes with a committing item
        else $error("flush raised without ms_valid_out");

endmodule

bind m1_stage m1_properties m1_properties_inst (.*);

`default_nettype wire

/* test/m1_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module m1_monitor (
    input  wire logic                clk,
    input  wire logic                active,
    input  wire logic [31:0]         vec_num,
    input  wire logic [31:0]         exp_mask,
    input  wire logic [31:0]         exp_flags,
    input  wire logic [31:0]         exp_target,
    input  wire logic [31:0]         exp_result,
    input  wire logic [31:0]         exp_req,
    input  wire logic [31:0]         exp_misc,
    input  wire logic                es_valid,
    input  wire m1_pkg::es_to_m1_t   es_bus,
    input  wire logic                m1_allowin,
    input  wire logic                ms_valid_out,
    input  wire m1_pkg::m1_to_ms_t   ms_bus,
    input  wire logic                dcache_valid,
    input  wire m1_pkg::dcache_req_t dcache_req,
    input  wire logic                flush,
    input  wire logic [31:0]         flush_target,
    input  wire logic                tlb_buffer_flush,
    input  wire logic [4:0]          fwd_dest,
    input  wire logic [31:0]         fwd_result,
    input  wire logic                fwd_load,
    input  wire logic                status_ie,
    input  wire logic                status_exl,
    input  wire logic [7:0]          status_im,
    input  wire logic [7:0]          cause_ip,
    input  wire logic [7:0]          entryhi_asid,
    output int                       error_count,
    output int                       check_count
);

    int                errors = 0;
    int                checks = 0;
    logic [9:0]        got_flags;
    m1_pkg::es_to_m1_t held;   // record taken by the last handshake

    // same bit order as the flags column of the vector file
    assign got_flags = {fwd_load, ms_bus.ex, dcache_req.uncached, status_ie, status_exl,
                        tlb_buffer_flush, flush, dcache_valid, ms_valid_out, m1_allowin};
    assign error_count = errors;
    assign check_count = checks;

    function automatic string flag_name(input int i);
        case (i)
            0:       return "m1_allowin";
            1:       return "ms_valid_out";
            2:       return "dcache_valid";
            3:       return "flush";
            4:       return "tlb_buffer_flush";
            5:       return "status_exl";
            6:       return "status_ie";
            7:       return "dcache_req.uncached";
            8:       return "ms_bus.ex";
            default: return "fwd_load";
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s in vector %0d: got %h, expected %h", name, vec_num, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (active) begin
            for (int i = 0; i < 10; i++) begin
                if (exp_mask[i])
                    compare_word(flag_name(i), {31'd0, got_flags[i]}, {31'd0, exp_flags[i]});
            end
            if (exp_mask[16])
                compare_word("flush_target", flush_target, exp_target);
            if (exp_mask[23])
                compare_word("ms_bus.pc", ms_bus.pc, exp_target);   // shares the target column
            if (exp_mask[17]) begin
                compare_word("ms_bus.result", ms_bus.result, exp_result);
                compare_word("fwd_result", fwd_result, exp_result);
            end
            if (exp_mask[18]) begin
                compare_word("dcache_req.tag", {12'd0, dcache_req.tag}, {12'd0, exp_req[19:0]});
                compare_word("dcache_req.index", {24'd0, dcache_req.index},
                             {24'd0, exp_req[27:20]});
                compare_word("dcache_req.offset", {28'd0, dcache_req.offset},
                             {28'd0, exp_req[31:28]});
            end
            if (exp_mask[19])
                compare_word("status_im", {24'd0, status_im}, {24'd0, exp_misc[7:0]});
            if (exp_mask[20])
                compare_word("cause_ip", {24'd0, cause_ip}, {24'd0, exp_misc[15:8]});
            if (exp_mask[21])
                compare_word("entryhi_asid", {24'd0, entryhi_asid}, {24'd0, exp_misc[23:16]});
            if (exp_mask[22]) begin
                compare_word("ms_bus.dest", {27'd0, ms_bus.dest}, {27'd0, exp_misc[28:24]});
                compare_word("fwd_dest", {27'd0, fwd_dest}, {27'd0, exp_misc[28:24]});
            end
            // fields that pass straight through from the held record
            if (exp_mask[1] && exp_flags[1]) begin
                compare_word("ms_bus.gr_we", {31'd0, ms_bus.gr_we}, {31'd0, held.gr_we});
                compare_word("ms_bus.load_op", {31'd0, ms_bus.load_op},
                             {31'd0, held.load_op});
                compare_word("ms_bus.rt_value", ms_bus.rt_value, held.rt_value);
            end
            if (exp_mask[2] && exp_flags[2]) begin
                compare_word("dcache_req.op", {31'd0, dcache_req.op}, {31'd0, held.mem_we});
                compare_word("dcache_req.wdata", dcache_req.wdata, held.wdata);
                if (held.mem_we)
                    compare_word("dcache_req.wstrb", {28'd0, dcache_req.wstrb},
                                 {28'd0, held.wstrb});
            end
        end
        if (es_valid && m1_allowin)
            held = es_bus;
    end

endmodule

`default_nettype wire

/* test/m1_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module m1_stage_tb;

    localparam int COLS            = 13;   // words per vector line
    localparam int MAX_VECS        = 64;
    localparam int ALLOWIN_TIMEOUT = 20;

    logic                clk;
    logic                reset;
    logic                es_valid;
    m1_pkg::es_to_m1_t   es_bus;
    logic                m1_allowin;
    logic                ms_allowin;
    logic                ms_valid_out;
    m1_pkg::m1_to_ms_t   ms_bus;
    logic [5:0]          ext_int;
    m1_pkg::tlb_lookup_t tlb_result;
    logic [7:0]          entryhi_asid;
    logic                dcache_valid;
    m1_pkg::dcache_req_t dcache_req;
    logic                dcache_busy;
    logic                flush;
    logic [31:0]         flush_target;
    logic                tlb_buffer_flush;
    logic [4:0]          fwd_dest;
    logic [31:0]         fwd_result;
    logic                fwd_load;
    logic                status_ie;
    logic                status_exl;
    logic [7:0]          status_im;
    logic [7:0]          cause_ip;

    logic [31:0] vec_mem [0:COLS*MAX_VECS-1];
    logic        active;
    int          vec_num;
    logic [31:0] exp_mask;
    logic [31:0] exp_flags;
    logic [31:0] exp_target;
    logic [31:0] exp_result;
    logic [31:0] exp_req;
    logic [31:0] exp_misc;
    int          error_count;
    int          check_count;

    m1_stage m1_stage_inst (.*);

    m1_monitor m1_monitor_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic m1_pkg::tlb_page_t unpack_page(input logic [31:0] word);
        m1_pkg::tlb_page_t page;
        page.pfn = word[31:12];
        page.c   = word[10:8];
        page.d   = word[4];
        page.v   = word[0];
        return page;
    endfunction

    function automatic bit end_marker(input int base);
        return vec_mem[base][31] === 1'b1 || $isunknown(vec_mem[base]);
    endfunction

    task automatic apply_vector(input int base);
        logic [31:0] ctl;
        logic [31:0] ops;
        ctl = vec_mem[base];
        ops = vec_mem[base+3];
        es_valid          = ctl[0];
        ms_allowin        = ctl[1];
        dcache_busy       = ctl[2];
        ext_int           = ctl[9:4];
        tlb_result.found  = ctl[12];
        tlb_result.even   = unpack_page(vec_mem[base+5]);
        tlb_result.odd    = unpack_page(vec_mem[base+6]);
        es_bus.pc         = vec_mem[base+1];
        es_bus.alu_result = vec_mem[base+2];
        es_bus.dest       = ops[4:0];
        es_bus.gr_we      = ops[5];
        es_bus.load_op    = ops[6];
        es_bus.mem_we     = ops[7];
        es_bus.wstrb      = ops[11:8];
        es_bus.inst_mfc0  = ops[12];
        es_bus.inst_mtc0  = ops[13];
        es_bus.inst_eret  = ops[14];
        es_bus.cp0_rd     = ops[19:15];
        es_bus.cp0_sel    = 3'd0;
        es_bus.bd         = ops[20];
        es_bus.ex         = ops[21];
        es_bus.exccode    = m1_pkg::exccode_e'(ops[26:22]);
        es_bus.wdata      = vec_mem[base+4];   // store data is rt
        es_bus.rt_value   = vec_mem[base+4];
        exp_mask          = vec_mem[base+7];
        exp_flags         = vec_mem[base+8];
        exp_target        = vec_mem[base+9];
        exp_result        = vec_mem[base+10];
        exp_req           = vec_mem[base+11];
        exp_misc          = vec_mem[base+12];
    endtask

    initial begin
        int nvec;
        int waited;
        int local_errors;
        reset        = 1'b1;
        es_valid     = 1'b0;
        es_bus       = '0;
        ms_allowin   = 1'b0;
        dcache_busy  = 1'b0;
        ext_int      = 6'd0;
        tlb_result   = '0;
        active       = 1'b0;
        vec_num      = 0;
        exp_mask     = '0;
        exp_flags    = '0;
        exp_target   = '0;
        exp_result   = '0;
        exp_req      = '0;
        exp_misc     = '0;
        local_errors = 0;
        $readmemh("test/m1_tests.dat", vec_mem);
        repeat (4) @(posedge clk);
        #2;
        reset      = 1'b0;
        ms_allowin = 1'b1;
        waited     = 0;
        while (m1_allowin !== 1'b1 && waited < ALLOWIN_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (m1_allowin !== 1'b1) begin
            $display("timeout: m1_allowin did not rise after reset");
            $display("** FAIL **");
            $finish;
        end else begin
            nvec = 0;
            while (nvec < MAX_VECS && !end_marker(nvec * COLS)) begin
                vec_num = nvec;
                apply_vector(nvec * COLS);
                active = 1'b1;
                @(posedge clk);   // monitor checks this vector here
                #2;
                nvec++;
            end
            active   = 1'b0;
            es_valid = 1'b0;
            if (nvec == 0) begin
                $display("no test vectors were read from the data file");
                local_errors++;
            end
            @(posedge clk);
            #2;
            $display("vectors %0d, checks %0d, errors %0d", nvec, check_count,
                     error_count + local_errors);
            if (error_count + local_errors == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/m1_tests.dat */
// ctl pc addr ops rt tlb_even tlb_odd | mask flags target result req misc, one vector per cycle
// ctl: 0 es_valid 1 ms_allowin 2 dcache_busy 9:4 ext_int 12 tlb found 31 end of vectors
// ops: 4:0 dest 5 gr_we 6 load 7 store 11:8 wstrb 12 mfc0 13 mtc0 14 eret 19:15 cp0_rd
//      20 bd 21 ex 26:22 exccode ; tlb page word: 31:12 pfn 10:8 c 4 d 0 v
// flags: allowin msvalid dvalid flush tlbflush exl ie uncached ex fwdload (bits 0..9)
// mask: 9:0 flags 16 target 17 result 18 req 19 im 20 ip 21 asid 22 dest 23 pc (target col)
2 0 0 0 0 0 0 0038007f 001 0 0 0 0
3 bfc00000 00001234 23 0 0 0 0000000f 001 0 0 0 0
3 bfc00004 00403a58 64 0 0 0 00e2037f 003 bfc00000 00001234 0 03000000
1003 bfc00008 00402100 f80 deadbeef 11111311 22222301 004603ff 207 0 00403a58 8a522222 04000000
1006 0 0 0 0 33333211 0 0000001f 000 0 0 0 0
1000 0 0 0 0 33333211 0 0000001f 002 0 0 0 0
1003 bfc0000c a0001234 65 0 33333211 0 0004009f 087 0 0 01033333 0
3 bfc00010 00405000 66 0 0 0 000603ff 287 0 a0001234 42300001 0
3 bfc00014 0 69027 0 0 0 0001037f 30b bfc00200 0 0 0
3 bfc00018 00406000 f80 0 0 0 0042037f 023 0 00000008 0 07000000
1003 bfc0001c 0 69027 0 44444310 0 0001037f 12b bfc00380 0 0 0
3 bfc00020 00407010 f80 12345678 0 0 0042037f 023 0 0000000c 0 07000000
1003 bfc00024 0 69027 0 0 55555301 0001037f 12b bfc00380 0 0 0
3 bfc00028 00408000 2200068 0 0 0 0042037f 023 0 00000004 0 07000000
3 bfc0002c 0 4000 0 0 0 0001037f 32b bfc00380 0 0 0
3 bfc00030 0 71029 0 0 0 0001037f 02b bfc00028 0 0 0
3 bfc00034 0 62000 0000ff01 0 0 0042037f 003 0 bfc00028 0 09000000
3 bfc00038 0 52000 8000e03c 0 0 0000037f 003 0 0 0 0
2d2 0 0 0 0 0 0 0029037f 05b bfc0003c 0 0 000000ff
2 0 0 0 0 0 0 0038007f 041 0 0 0 003cb4ff
2 0 0 0 0 0 0 0038007f 041 0 0 0 003c00ff
80000000 0 0 0 0 0 0 0 0 0 0 0 0

/* mips_m1.f */
+incdir+verilog
verilog/m1_pkg.sv
verilog/dtlb_check.sv
verilog/cp0_regs.sv
verilog/m1_stage.sv
test/m1_properties.sv
test/m1_monitor.sv
test/m1_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= m1_stage_tb
FLIST     ?= mips_m1.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
